// ==== compile.f ====
src/axis_pkg.sv
src/axis_beat_if.sv
src/axis_ingress.sv
src/beat_fifo.sv
src/packet_stats.sv
src/axis_stream_top.sv
sim/axis_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, then run it
# a $fatal in the testbench gives a non-zero exit status
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module axis_tb -f compile.f -o axis_sim &&
  ./obj_dir/axis_sim ||
  { echo "build or simulation failed"; exit 1; }

// ==== sim/axis_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_tb import axis_pkg::*; ();

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 5;
  localparam int NUM_PKTS        = 60;
  localparam int CYCLES_PER_PKT  = 60;
  localparam int STALL_CYCLES    = 30;
  localparam int STALL_PKT       = 40;      // stall starts with this packet
  localparam int BAD_PKT         = 20;      // last beat gets a gapped keep
  localparam int DRAIN_CYCLES    = 200;     // beats in flight after the last send
  localparam int WATCHDOG_CYCLES = NUM_PKTS * CYCLES_PER_PKT + STALL_CYCLES +
                                   RESET_CYCLES + DRAIN_CYCLES + 100;
  localparam keep_t BAD_KEEP     = 4'b0101;

  logic                    aclk;
  logic                    i_rst;
  logic                    i_s_valid;
  logic                    o_s_ready;
  beat_data_t              i_s_data;
  keep_t                   i_s_keep;
  logic                    i_s_last;
  logic                    o_m_valid;
  logic                    i_m_ready;
  beat_data_t              o_m_data;
  keep_t                   o_m_keep;
  logic                    o_m_last;
  logic                    o_pkt_valid;
  logic [CNT_W-1:0]        o_pkt_words;
  logic signed [SUM_W-1:0] o_pkt_sum;
  logic                    o_protocol_err;

  // reference model state
  beat_data_t              data_q[$];
  keep_t                   keep_q[$];
  logic                    last_q[$];
  logic [CNT_W-1:0]        words_q[$];
  logic signed [SUM_W-1:0] sums_q[$];
  beat_data_t              head_data;
  keep_t                   head_keep;
  logic                    head_last;
  logic                    head_avail;
  logic [CNT_W-1:0]        head_words;
  logic signed [SUM_W-1:0] head_sum;
  logic                    rep_avail;
  logic                    s_xfer_pending;
  logic                    m_pop_pending;
  logic                    rep_pop_pending;
  logic                    bad_accepted;
  logic                    saw_ready_low;
  int                      stall_left;

  axis_stream_top dut_i (.*);

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    report_failure($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
  endtask

  // expected heads are updated on falling edges, stable at the rising edge
  function automatic void update_heads();
    head_avail = (data_q.size() > 0);
    if (head_avail) begin
      head_data = data_q[0];
      head_keep = keep_q[0];
      head_last = last_q[0];
    end
    rep_avail = (words_q.size() > 0);
    if (rep_avail) begin
      head_words = words_q[0];
      head_sum   = sums_q[0];
    end
  endfunction

  // falling-edge bookkeeping for the rising edge just past and the new m_ready
  task automatic settle_cycle();
    if (m_pop_pending) begin
      void'(data_q.pop_front());
      void'(keep_q.pop_front());
      void'(last_q.pop_front());
    end
    if (rep_pop_pending) begin
      void'(words_q.pop_front());
      void'(sums_q.pop_front());
    end
    if (s_xfer_pending) begin
      i_s_valid      = 1'b0;
      s_xfer_pending = 1'b0;
    end
    if (stall_left > 0) begin
      i_m_ready  = 1'b0;
      stall_left = stall_left - 1;
      if (!o_s_ready) saw_ready_low = 1'b1;
    end else begin
      i_m_ready = ($urandom_range(99) < 70);
    end
    m_pop_pending   = o_m_valid && i_m_ready;   // transfers at the next rising edge
    rep_pop_pending = o_pkt_valid;
  endtask

  task automatic send_beat(input beat_data_t d, input keep_t k, input logic l,
                           input logic bad);
    logic sent;
    sent = 1'b0;
    while (!sent) begin
      @(negedge aclk);
      settle_cycle();
      if (!i_s_valid && (stall_left > 0 || $urandom_range(99) < 70)) begin
        i_s_valid = 1'b1;
        i_s_data  = d;
        i_s_keep  = k;
        i_s_last  = l;
      end
      if (i_s_valid && o_s_ready) begin
        data_q.push_back(d);
        keep_q.push_back(k);
        last_q.push_back(l);
        s_xfer_pending = 1'b1;
        if (bad) bad_accepted = 1'b1;
        sent = 1'b1;
      end
      update_heads();
    end
  endtask

  // splits len words into beats and keeps a running count and sum of kept words
  task automatic send_packet(input int len, input logic bad);
    beat_data_t              d;
    keep_t                   k;
    int                      left;
    int                      n;
    logic [CNT_W-1:0]        words;
    logic signed [SUM_W-1:0] sum;
    left  = len;
    words = '0;
    sum   = '0;
    while (left > 0) begin
      n    = (left > LANES) ? LANES : left;
      left = left - n;
      k    = keep_t'((1 << n) - 1);
      if (bad && left == 0) k = BAD_KEEP;
      for (int i = 0; i < LANES; i++) begin
        d[i] = word_t'($urandom());
        if (k[i]) begin
          words = words + CNT_W'(1);
          sum   = sum + SUM_W'(d[i]);     // sign extended and wrapped to 16 bits
        end
      end
      send_beat(d, k, (left == 0), bad && (left == 0));
    end
    words_q.push_back(words);
    sums_q.push_back(sum);
  endtask

  initial begin
    int len;
    int drain_left;
    void'($urandom(37));
    i_rst           = 1'b1;
    i_s_valid       = 1'b0;
    i_s_data        = '0;
    i_s_keep        = '0;
    i_s_last        = 1'b0;
    i_m_ready       = 1'b0;
    s_xfer_pending  = 1'b0;
    m_pop_pending   = 1'b0;
    rep_pop_pending = 1'b0;
    bad_accepted    = 1'b0;
    saw_ready_low   = 1'b0;
    stall_left      = 0;
    update_heads();
    repeat (RESET_CYCLES) @(negedge aclk);
    i_rst = 1'b0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      if (p == STALL_PKT) stall_left = STALL_CYCLES;
      len = $urandom_range(40, 1);
      send_packet(len, (p == BAD_PKT));
    end
    drain_left = DRAIN_CYCLES;
    while ((data_q.size() != 0 || words_q.size() != 0) && drain_left > 0) begin
      @(negedge aclk);
      settle_cycle();
      update_heads();
      drain_left = drain_left - 1;
    end
    repeat (10) begin                     // catch stray beats or pulses
      @(negedge aclk);
      settle_cycle();
      update_heads();
    end
    if (!saw_ready_low) begin
      report_mismatch("o_s_ready never dropped during the stall");
    end else if (data_q.size() == 0 && words_q.size() == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      report_mismatch("expected beats or reports left over at the end");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("timeout: the run did not finish in the allowed number of cycles");
  end

  a_reset_idle: assert property (@(posedge aclk) disable iff (i_rst)
    $fell(i_rst) |-> o_s_ready && !o_m_valid && !o_pkt_valid && !o_protocol_err)
    else report_mismatch("outputs not idle right after reset");

  a_beat_match: assert property (@(posedge aclk) disable iff (i_rst)
    o_m_valid && i_m_ready |->
      head_avail && o_m_data == head_data && o_m_keep == head_keep &&
      o_m_last == head_last)
    else report_mismatch("m_ beat differs from the expected beat");

  a_beat_hold: assert property (@(posedge aclk) disable iff (i_rst)
    o_m_valid && !i_m_ready |=>
      o_m_valid && $stable(o_m_data) && $stable(o_m_keep) && $stable(o_m_last))
    else report_mismatch("m_ beat changed while stalled");

  a_report_match: assert property (@(posedge aclk) disable iff (i_rst)
    o_pkt_valid |-> rep_avail && o_pkt_words == head_words && o_pkt_sum == head_sum)
    else report_mismatch("packet report differs from the expected count or sum");

  a_report_after_last: assert property (@(posedge aclk) disable iff (i_rst)
    o_m_valid && i_m_ready && o_m_last |=> o_pkt_valid)
    else report_mismatch("no report pulse after the last beat");

  a_report_only_after_last: assert property (@(posedge aclk) disable iff (i_rst)
    o_pkt_valid |-> $past(o_m_valid && i_m_ready && o_m_last))
    else report_mismatch("report pulse without a last beat before it");

  a_err_sticky: assert property (@(posedge aclk) disable iff (i_rst)
    o_protocol_err |=> o_protocol_err)
    else report_mismatch("o_protocol_err cleared without reset");

  a_err_quiet: assert property (@(posedge aclk) disable iff (i_rst)
    !bad_accepted |-> !o_protocol_err)
    else report_mismatch("o_protocol_err set before any malformed beat");

  a_err_raised: assert property (@(posedge aclk) disable iff (i_rst)
    $past(bad_accepted, 2) |-> o_protocol_err)
    else report_mismatch("o_protocol_err not set after the malformed beat");

endmodule

`default_nettype wire

// ==== src/axis_beat_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface axis_beat_if import axis_pkg::*; ();

  logic       valid;
  logic       ready;
  beat_data_t data;
  keep_t      keep;
  logic       last;
  nwords_t    nwords;   // kept words in this beat, set at ingress

  // upstream side of a link
  modport src (
    output valid,
    input  ready,
    output data,
    output keep,
    output last,
    output nwords
  );

  // downstream side of a link
  modport snk (
    input  valid,
    output ready,
    input  data,
    input  keep,
    input  last,
    input  nwords
  );

endinterface

`default_nettype wire

// ==== src/axis_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_ingress import axis_pkg::*; (
  input  wire logic       i_aclk,
  input  wire logic       i_rst,
  input  wire logic       i_s_valid,
  output logic            o_s_ready,
  input  wire beat_data_t i_s_data,
  input  wire keep_t      i_s_keep,
  input  wire logic       i_s_last,
  output logic            o_err,
  axis_beat_if.src        out
);

  slot_state_t state_q;
  beat_data_t  data_q;
  keep_t       keep_q;
  logic        last_q;
  nwords_t     nwords_q;
  logic        accept;
  logic        keep_gap;
  logic        keep_short;

  function automatic nwords_t count_keep(input keep_t k);
    nwords_t n;
    n = '0;
    for (int i = 0; i < LANES; i++) begin
      n = n + nwords_t'(k[i]);
    end
    return n;
  endfunction

  // a contiguous mask from lane 0 has no bit set above a zero
  assign keep_gap   = (i_s_keep & (i_s_keep + keep_t'(1))) != '0;
  assign keep_short = !i_s_last && (i_s_keep != '1);  // only the last beat may be partial

  assign o_s_ready = (state_q == SLOT_EMPTY) || out.ready;
  assign accept    = i_s_valid && o_s_ready;

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state_q <= SLOT_EMPTY;
      o_err   <= 1'b0;
    end else begin
      o_err <= accept && (keep_gap || keep_short);
      if (accept) begin
        state_q <= SLOT_FULL;
      end else if (out.ready) begin
        state_q <= SLOT_EMPTY;            // slot drained, nothing new
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (accept) begin
      data_q   <= i_s_data;
      keep_q   <= i_s_keep;
      last_q   <= i_s_last;
      nwords_q <= count_keep(i_s_keep);
    end
  end

  assign out.valid  = (state_q == SLOT_FULL);
  assign out.data   = data_q;
  assign out.keep   = keep_q;
  assign out.last   = last_q;
  assign out.nwords = nwords_q;

  // held beat must not change under back-pressure
  a_hold_payload: assert property (
    @(posedge i_aclk) disable iff (i_rst)
    out.valid && !out.ready |=>
      out.valid && $stable(out.data) && $stable(out.keep) &&
      $stable(out.last) && $stable(out.nwords)
  );

endmodule

`default_nettype wire

// ==== src/axis_pkg.sv ====
`default_nettype none

package axis_pkg;

  // beat geometry
  localparam int LANES      = 4;           // words per beat
  localparam int WORD_W     = 8;           // bits per word
  localparam int NWORDS_W   = 3;           // holds 0..LANES

  // beat fifo sizing
  localparam int FIFO_DEPTH = 8;           // power of two so pointers wrap naturally
  localparam int PTR_W      = $clog2(FIFO_DEPTH);

  // packet report widths
  localparam int CNT_W      = 10;          // up to 1023 words per packet
  localparam int SUM_W      = 16;          // wraps on overflow

  typedef logic signed [WORD_W-1:0] word_t;
  typedef word_t [LANES-1:0]        beat_data_t;  // lane 0 is the first word
  typedef logic [LANES-1:0]         keep_t;       // bit n marks lane n kept
  typedef logic [NWORDS_W-1:0]      nwords_t;

  typedef enum logic {
    SLOT_EMPTY,
    SLOT_FULL
  } slot_state_t;

endpackage

`default_nettype wire

// ==== src/axis_stream_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_stream_top import axis_pkg::*; (
  input  wire logic               aclk,
  input  wire logic               i_rst,

  // slave side
  input  wire logic               i_s_valid,
  output logic                    o_s_ready,
  input  wire beat_data_t         i_s_data,
  input  wire keep_t              i_s_keep,
  input  wire logic               i_s_last,

  // master side
  output logic                    o_m_valid,
  input  wire logic               i_m_ready,
  output beat_data_t              o_m_data,
  output keep_t                   o_m_keep,
  output logic                    o_m_last,

  // per-packet report
  output logic                    o_pkt_valid,
  output logic [CNT_W-1:0]        o_pkt_words,
  output logic signed [SUM_W-1:0] o_pkt_sum,

  output logic                    o_protocol_err
);

  logic ingress_err;     // one pulse per malformed beat

  axis_beat_if link_in_q ();   // ingress -> fifo
  axis_beat_if link_out_q ();  // fifo -> stats

  axis_ingress u_ingress (
    .i_aclk    (aclk),
    .i_rst     (i_rst),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .i_s_last  (i_s_last),
    .o_err     (ingress_err),
    .out       (link_in_q.src)
  );

  beat_fifo u_fifo (
    .i_aclk (aclk),
    .i_rst  (i_rst),
    .wr     (link_in_q.snk),
    .rd     (link_out_q.src)
  );

  packet_stats u_stats (
    .i_aclk      (aclk),
    .i_rst       (i_rst),
    .in          (link_out_q.snk),
    .o_m_valid   (o_m_valid),
    .i_m_ready   (i_m_ready),
    .o_m_data    (o_m_data),
    .o_m_keep    (o_m_keep),
    .o_m_last    (o_m_last),
    .o_pkt_valid (o_pkt_valid),
    .o_pkt_words (o_pkt_words),
    .o_pkt_sum   (o_pkt_sum)
  );

  // sticky until reset
  always_ff @(posedge aclk) begin
    if (i_rst) begin
      o_protocol_err <= 1'b0;
    end else if (ingress_err) begin
      o_protocol_err <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/beat_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_fifo import axis_pkg::*; (
  input  wire logic i_aclk,
  input  wire logic i_rst,
  axis_beat_if.snk  wr,
  axis_beat_if.src  rd
);

  beat_data_t mem_data   [FIFO_DEPTH];
  keep_t      mem_keep   [FIFO_DEPTH];
  logic       mem_last   [FIFO_DEPTH];
  nwords_t    mem_nwords [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;      // entries in mem, output register excluded
  logic             full;
  logic             wr_en;
  logic             load;

  logic       out_valid;
  beat_data_t out_data;
  keep_t      out_keep;
  logic       out_last;
  nwords_t    out_nwords;

  assign full     = (count == (PTR_W+1)'(FIFO_DEPTH));
  assign wr.ready = !full;
  assign wr_en    = wr.valid && !full;

  // refill the output register when it is empty or being taken
  assign load = (count != '0) && (!out_valid || rd.ready);

  always_ff @(posedge i_aclk) begin
    if (wr_en) begin
      mem_data[wr_ptr]   <= wr.data;
      mem_keep[wr_ptr]   <= wr.keep;
      mem_last[wr_ptr]   <= wr.last;
      mem_nwords[wr_ptr] <= wr.nwords;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (load) begin
        rd_ptr    <= rd_ptr + PTR_W'(1);
        out_valid <= 1'b1;
      end else if (rd.ready) begin
        out_valid <= 1'b0;
      end
      case ({wr_en, load})
        2'b10:   count <= count + (PTR_W+1)'(1);
        2'b01:   count <= count - (PTR_W+1)'(1);
        default: count <= count;          // none, or one in and one out
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (load) begin
      out_data   <= mem_data[rd_ptr];
      out_keep   <= mem_keep[rd_ptr];
      out_last   <= mem_last[rd_ptr];
      out_nwords <= mem_nwords[rd_ptr];
    end
  end

  assign rd.valid  = out_valid;
  assign rd.data   = out_data;
  assign rd.keep   = out_keep;
  assign rd.last   = out_last;
  assign rd.nwords = out_nwords;

  // a full queue takes no write
  a_no_write_full: assert property (
    @(posedge i_aclk) disable iff (i_rst)
    full |=> $stable(wr_ptr)
  );

  a_occupancy: assert property (
    @(posedge i_aclk) disable iff (i_rst)
    count <= (PTR_W+1)'(FIFO_DEPTH)
  );

endmodule

`default_nettype wire

// ==== src/packet_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_stats import axis_pkg::*; (
  input  wire logic              i_aclk,
  input  wire logic              i_rst,
  axis_beat_if.snk               in,
  output logic                   o_m_valid,
  input  wire logic              i_m_ready,
  output beat_data_t             o_m_data,
  output keep_t                  o_m_keep,
  output logic                   o_m_last,
  output logic                   o_pkt_valid,
  output logic [CNT_W-1:0]       o_pkt_words,
  output logic signed [SUM_W-1:0] o_pkt_sum
);

  slot_state_t             state_q;
  nwords_t                 nwords_q;
  logic [CNT_W-1:0]        cnt_acc;
  logic signed [SUM_W-1:0] sum_acc;
  logic [CNT_W-1:0]        cnt_next;
  logic signed [SUM_W-1:0] sum_next;
  logic                    accept;
  logic                    m_xfer;

  function automatic logic signed [SUM_W-1:0] sum_kept(input beat_data_t d,
                                                       input keep_t k);
    logic signed [SUM_W-1:0] s;
    word_t                   w;
    s = '0;
    for (int i = 0; i < LANES; i++) begin
      w = d[i];
      if (k[i]) begin
        s = s + {{(SUM_W-WORD_W){w[WORD_W-1]}}, w};  // sign extend
      end
    end
    return s;
  endfunction

  assign o_m_valid = (state_q == SLOT_FULL);
  assign m_xfer    = o_m_valid && i_m_ready;
  assign in.ready  = (state_q == SLOT_EMPTY) || i_m_ready;
  assign accept    = in.valid && in.ready;

  // totals including the beat now on m_
  assign cnt_next = cnt_acc + CNT_W'(nwords_q);
  assign sum_next = sum_acc + sum_kept(o_m_data, o_m_keep);

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state_q     <= SLOT_EMPTY;
      cnt_acc     <= '0;
      sum_acc     <= '0;
      o_pkt_valid <= 1'b0;
    end else begin
      if (accept) begin
        state_q <= SLOT_FULL;
      end else if (i_m_ready) begin
        state_q <= SLOT_EMPTY;
      end
      o_pkt_valid <= m_xfer && o_m_last;
      if (m_xfer) begin
        if (o_m_last) begin
          cnt_acc <= '0;                  // next packet starts fresh
          sum_acc <= '0;
        end else begin
          cnt_acc <= cnt_next;
          sum_acc <= sum_next;
        end
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (accept) begin
      o_m_data <= in.data;
      o_m_keep <= in.keep;
      o_m_last <= in.last;
      nwords_q <= in.nwords;
    end
    if (m_xfer && o_m_last) begin
      o_pkt_words <= cnt_next;
      o_pkt_sum   <= sum_next;
    end
  end

  // accumulators restart together with every report
  a_acc_cleared: assert property (
    @(posedge i_aclk) disable iff (i_rst)
    o_pkt_valid |-> cnt_acc == '0 && sum_acc == '0
  );

endmodule

`default_nettype wire
